// ==== vp_pkg.sv ====
/*
 * Shared types and constants for the console glue logic
 * Video standard, pixel code, colour channel and key types
 * Clock enable periods and cartridge size thresholds
 */
`default_nettype none

package vp_pkg;

	////////////////////////////////////////////////////////////////////////
	// Types

	typedef logic video_std_t;        // 0 NTSC, 1 PAL

	localparam video_std_t STD_NTSC = 1'b0;
	localparam video_std_t STD_PAL  = 1'b1;

	typedef logic [3:0] pixel_code_t; // R, G, B, luma from MSB down
	typedef logic [5:0] chan_t;
	typedef logic [7:0] ascii_t;

	// Toggle, pressed, extended, scan code
	typedef logic [10:0] ps2_key_t;

	// Bit 0 is "1" ... bit 8 is "9", bit 9 is "0"
	typedef logic [9:0] numpad_t;

	typedef logic [11:0] cart_addr_t;

	////////////////////////////////////////////////////////////////////////
	// Constants

	// Enable periods in clk_sys cycles
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;

	localparam int CART_ROM_AW = 13;  // 8 KB cartridge store

	// Image sizes that unlock the bank select bits
	localparam int BANK0_SIZE = 4096;
	localparam int BANK1_SIZE = 8192;

endpackage

`default_nettype wire

// ==== vp_timing_ctrl.sv ====
/*
 * CPU and VDC clock enable dividers
 * Core reset from system reset, download and standard change
 */
`timescale 1ns/1ps
`default_nettype none

module vp_timing_ctrl import vp_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  video_std_t pal_i,
	input  wire        download_i,
	output logic       cpu_en_o,
	output logic       vdc_en_o,
	output logic       core_reset_o
);

	// Terminal counts one below the period
	localparam logic [3:0] CPU_LAST_NTSC = 4'(CPU_DIV_NTSC - 1);
	localparam logic [3:0] CPU_LAST_PAL  = 4'(CPU_DIV_PAL - 1);
	localparam logic [3:0] VDC_LAST_NTSC = 4'(VDC_DIV_NTSC - 1);
	localparam logic [3:0] VDC_LAST_PAL  = 4'(VDC_DIV_PAL - 1);

	logic [3:0] cpu_cnt;
	logic [3:0] vdc_cnt;
	logic [3:0] cpu_last;
	logic [3:0] vdc_last;
	video_std_t pal_q;
	logic       pal_chg;

	assign cpu_last = (pal_i == STD_PAL) ? CPU_LAST_PAL : CPU_LAST_NTSC;
	assign vdc_last = (pal_i == STD_PAL) ? VDC_LAST_PAL : VDC_LAST_NTSC;

	// Registered copy of the standard
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	assign pal_chg = (pal_q != pal_i);
	assign core_reset_o = reset | download_i | pal_chg;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= 4'd0;
			vdc_cnt  <= 4'd0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else if (pal_chg) begin // Restart both dividers
			cpu_cnt  <= 4'd0;
			vdc_cnt  <= 4'd0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			cpu_en_o <= (cpu_cnt >= cpu_last);
			cpu_cnt  <= (cpu_cnt >= cpu_last) ? 4'd0 : cpu_cnt + 4'd1;
			vdc_en_o <= (vdc_cnt >= vdc_last);
			vdc_cnt  <= (vdc_cnt >= vdc_last) ? 4'd0 : vdc_cnt + 4'd1;
		end
	end

endmodule

`default_nettype wire

// ==== vp_palette.sv ====
/*
 * Pixel code to RGB colour lookup
 * Calibrated NTSC table and PAL table, 6 bits per channel, registered
 */
`timescale 1ns/1ps
`default_nettype none

module vp_palette import vp_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset,
	input  video_std_t  pal_i,
	input  pixel_code_t pixel_i,
	output chan_t       r_o,
	output chan_t       g_o,
	output chan_t       b_o
);

	// Calibrated NTSC colours at 8 bits per channel
	localparam logic [23:0] LUT_NTSC [16] = '{
		24'h000000, 24'h676767,  // Black
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,  // Red
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff   // White
	};

	localparam logic [23:0] LUT_PAL [16] = '{
		24'h000000, 24'h494949,  // Black
		24'h0000b6, 24'h4949ff,  // Blue
		24'h00b601, 24'h49ff49,  // Green
		24'h00b6c9, 24'h49ffff,  // Cyan
		24'hb60000, 24'hff4949,  // Red
		24'hb600b6, 24'hff49ff,  // Magenta
		24'hb6b600, 24'hffff49,  // Yellow
		24'hb6b6b6, 24'hffffff   // White
	};

	logic [23:0] rgb;

	assign rgb = (pal_i == STD_PAL) ? LUT_PAL[pixel_i] : LUT_NTSC[pixel_i];

	// Keep the upper six bits of each byte
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			r_o <= '0;
			g_o <= '0;
			b_o <= '0;
		end else begin
			r_o <= rgb[23:18];
			g_o <= rgb[15:10];
			b_o <= rgb[7:2];
		end
	end

endmodule

`default_nettype wire

// ==== vp_key_event.sv ====
/*
 * First key stage
 * Detects PS/2 event toggles and numpad vector changes
 */
`timescale 1ns/1ps
`default_nettype none

module vp_key_event import vp_pkg::*; (
	input  wire      clk_sys,
	input  wire      reset,
	input  ps2_key_t ps2_key_i,
	input  numpad_t  numpad_i,
	output logic     ev_valid_o,
	output logic     ev_is_ps2_o,
	output ps2_key_t ev_code_o,
	output numpad_t  ev_numpad_o
);

	logic    toggle_q;
	numpad_t numpad_q;
	logic    ps2_tog;
	logic    np_chg;

	assign ps2_tog = (toggle_q != ps2_key_i[10]);
	assign np_chg  = (numpad_q != numpad_i);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q   <= 1'b0;
			numpad_q   <= '0;
			ev_valid_o <= 1'b0;
		end else begin
			toggle_q   <= ps2_key_i[10];
			numpad_q   <= numpad_i; // Updated even when the PS/2 event wins
			ev_valid_o <= ps2_tog | np_chg;
		end
	end

	// Event payload qualified by ev_valid_o
	always_ff @(posedge clk_sys) begin
		ev_is_ps2_o <= ps2_tog;     // PS/2 has priority
		ev_code_o   <= ps2_key_i;
		ev_numpad_o <= numpad_i;
	end

endmodule

`default_nettype wire

// ==== vp_key_translate.sv ====
/*
 * Second key stage
 * PS/2 scan codes and joystick numpad to ASCII key events
 */
`timescale 1ns/1ps
`default_nettype none

module vp_key_translate import vp_pkg::*; (
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      ev_valid_i,
	input  wire      ev_is_ps2_i,
	input  ps2_key_t ev_code_i,
	input  numpad_t  ev_numpad_i,
	output logic     key_valid_o,
	output ascii_t   key_ascii_o,
	output logic     key_released_o
);

	//////////////////////////////////////////////////////////////////////
	// Scan code table ignoring the extended bit

	function automatic ascii_t scan_to_ascii(input logic [7:0] sc);
		ascii_t c;
		case (sc)
			8'h16: c = "1";
			8'h1e: c = "2";
			8'h26: c = "3";
			8'h25: c = "4";
			8'h2e: c = "5";
			8'h36: c = "6";
			8'h3d: c = "7";
			8'h3e: c = "8";
			8'h46: c = "9";
			8'h45: c = "0";
			8'h1c: c = "a";
			8'h32: c = "b";
			8'h21: c = "c";
			8'h23: c = "d";
			8'h24: c = "e";
			8'h2b: c = "f";
			8'h34: c = "g";
			8'h33: c = "h";
			8'h43: c = "i";
			8'h3b: c = "j";
			8'h42: c = "k";
			8'h4b: c = "l";
			8'h3a: c = "m";
			8'h31: c = "n";
			8'h44: c = "o";
			8'h4d: c = "p";
			8'h15: c = "q";
			8'h2d: c = "r";
			8'h1b: c = "s";
			8'h2c: c = "t";
			8'h3c: c = "u";
			8'h2a: c = "v";
			8'h1d: c = "w";
			8'h22: c = "x";
			8'h35: c = "y";
			8'h1a: c = "z";
			8'h29: c = " ";
			8'h79: c = "+";
			8'h7b: c = "-";
			8'h7c: c = "*";
			8'h4a: c = "/";
			8'h55: c = "=";
			8'h1f: c = 8'h11; // Left GUI as yes
			8'h27: c = 8'h12; // Right GUI as no
			8'h5a: c = 8'h0a; // Enter
			8'h66: c = 8'h08; // Backspace
			default: c = 8'h00;
		endcase
		return c;
	endfunction

	// Lowest pressed button gives the digit
	function automatic ascii_t numpad_digit(input numpad_t np);
		ascii_t d;
		d = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (np[i])
				d = (i == 9) ? "0" : ascii_t'(8'h31 + i);
		end
		return d;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output register

	ascii_t joy_last;   // Last joystick digit for the release event
	logic   np_pressed;

	assign np_pressed = (ev_numpad_i != '0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_valid_o <= 1'b0;
			joy_last    <= 8'h00;
		end else begin
			key_valid_o <= ev_valid_i;
			if (ev_valid_i && !ev_is_ps2_i && np_pressed)
				joy_last <= numpad_digit(ev_numpad_i);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ev_valid_i) begin
			if (ev_is_ps2_i) begin
				key_ascii_o    <= scan_to_ascii(ev_code_i[7:0]);
				key_released_o <= ~ev_code_i[9];
			end else if (np_pressed) begin
				key_ascii_o    <= numpad_digit(ev_numpad_i);
				key_released_o <= 1'b0;
			end else begin
				key_ascii_o    <= joy_last; // All buttons up
				key_released_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== vp_cart_map.sv ====
/*
 * Cartridge download size counter
 * Bank-switched ROM address and download write enable
 */
`timescale 1ns/1ps
`default_nettype none

module vp_cart_map import vp_pkg::*; #(
	parameter int AW = 13
) (
	input  wire           clk_sys,
	input  wire           reset,
	input  wire           download_i,
	input  wire           wr_i,
	input  wire  [AW-1:0] dl_addr_i,
	input  cart_addr_t    cart_a_i,
	input  wire           bs0_i,
	input  wire           bs1_i,
	output logic [AW-1:0] rom_addr_o,
	output logic          rom_we_o
);

	logic [15:0] cart_size;
	logic        dl_q;
	logic [12:0] bank_addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q      <= 1'b0;
			cart_size <= 16'd0;
		end else begin
			dl_q <= download_i;
			if (download_i && !dl_q)     // New image starts
				cart_size <= 16'd0;
			else if (download_i && wr_i)
				cart_size <= cart_size + 16'd1;
		end
	end

	// Bank bits only count once the image is large enough
	assign bank_addr = {(cart_size >= BANK1_SIZE) ? bs1_i : 1'b0,
		(cart_size >= BANK0_SIZE) ? bs0_i : 1'b0, cart_a_i[11], cart_a_i[9:0]};

	assign rom_addr_o = download_i ? dl_addr_i : AW'(bank_addr);
	assign rom_we_o   = download_i & wr_i;

endmodule

`default_nettype wire

// ==== vp_cart_rom.sv ====
/*
 * Cartridge byte memory
 * Written by download, registered read, FF outside program store reads
 */
`timescale 1ns/1ps
`default_nettype none

module vp_cart_rom #(
	parameter int AW = 13
) (
	input  wire          clk_sys,
	input  wire [AW-1:0] addr_i,
	input  wire          we_i,
	input  wire    [7:0] data_i,
	input  wire          psen_n_i,
	output logic   [7:0] data_o
);

	logic [7:0] mem [2**AW];

	always_ff @(posedge clk_sys) begin
		if (we_i)
			mem[addr_i] <= data_i;
		data_o <= psen_n_i ? 8'hff : mem[addr_i]; // Bus idles high
	end

endmodule

`default_nettype wire

// ==== vp_glue_top.sv ====
/*
 * Board glue top level
 * Timing, palette, two-stage key path and cartridge store
 */
`timescale 1ns/1ps
`default_nettype none

module vp_glue_top import vp_pkg::*; #(
	parameter int CART_ROM_AW = vp_pkg::CART_ROM_AW
) (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  video_std_t            pal_i,
	input  wire                   download_i,
	input  wire                   wr_i,
	input  wire [CART_ROM_AW-1:0] dl_addr_i,
	input  wire             [7:0] dl_data_i,
	input  cart_addr_t            cart_a_i,
	input  wire                   bs0_i,
	input  wire                   bs1_i,
	input  wire                   psen_n_i,
	output logic            [7:0] cart_d_o,
	input  pixel_code_t           pixel_i,
	output chan_t                 r_o,
	output chan_t                 g_o,
	output chan_t                 b_o,
	input  ps2_key_t              ps2_key_i,
	input  numpad_t               numpad_i,
	output logic                  key_valid_o,
	output ascii_t                key_ascii_o,
	output logic                  key_released_o,
	output logic                  cpu_en_o,
	output logic                  vdc_en_o,
	output logic                  core_reset_o
);

	logic                   ev_valid;
	logic                   ev_is_ps2;
	ps2_key_t               ev_code;
	numpad_t                ev_numpad;
	logic [CART_ROM_AW-1:0] rom_addr;
	logic                   rom_we;

	//////////////////////////////////////////////////////////////////////
	// Timing and video

	vp_timing_ctrl i_timing (
		.clk_sys(clk_sys), .reset(reset), .pal_i(pal_i), .download_i(download_i),
		.cpu_en_o(cpu_en_o), .vdc_en_o(vdc_en_o), .core_reset_o(core_reset_o)
	);

	vp_palette i_palette (
		.clk_sys(clk_sys), .reset(reset), .pal_i(pal_i), .pixel_i(pixel_i),
		.r_o(r_o), .g_o(g_o), .b_o(b_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Key path

	vp_key_event i_key_event (
		.clk_sys(clk_sys), .reset(reset), .ps2_key_i(ps2_key_i), .numpad_i(numpad_i),
		.ev_valid_o(ev_valid), .ev_is_ps2_o(ev_is_ps2),
		.ev_code_o(ev_code), .ev_numpad_o(ev_numpad)
	);

	vp_key_translate i_key_translate (
		.clk_sys(clk_sys), .reset(reset), .ev_valid_i(ev_valid),
		.ev_is_ps2_i(ev_is_ps2), .ev_code_i(ev_code), .ev_numpad_i(ev_numpad),
		.key_valid_o(key_valid_o), .key_ascii_o(key_ascii_o),
		.key_released_o(key_released_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Cartridge

	vp_cart_map #(.AW(CART_ROM_AW)) i_cart_map (
		.clk_sys(clk_sys), .reset(reset), .download_i(download_i), .wr_i(wr_i),
		.dl_addr_i(dl_addr_i), .cart_a_i(cart_a_i), .bs0_i(bs0_i), .bs1_i(bs1_i),
		.rom_addr_o(rom_addr), .rom_we_o(rom_we)
	);

	vp_cart_rom #(.AW(CART_ROM_AW)) i_cart_rom (
		.clk_sys(clk_sys), .addr_i(rom_addr), .we_i(rom_we), .data_i(dl_data_i),
		.psen_n_i(psen_n_i), .data_o(cart_d_o)
	);

endmodule

`default_nettype wire

// ==== tb_vp_checks.svh ====
/*
 * Compare tasks for the glue testbench
 * One task per result kind: bit, colour channel, key character, byte
 */
`ifndef TB_VP_CHECKS_SVH
`define TB_VP_CHECKS_SVH

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("MISMATCH %s expected %b actual %b", name, exp, act);
		$display("Some tests failed");
		$fatal(1, "bit compare");
	end
endtask

task automatic check_chan(input string name, input chan_t exp, input chan_t act);
	if (act !== exp) begin
		$display("MISMATCH %s expected %h actual %h", name, exp, act);
		$display("Some tests failed");
		$fatal(1, "channel compare");
	end
endtask

task automatic check_ascii(input string name, input ascii_t exp, input ascii_t act);
	if (act !== exp) begin
		$display("MISMATCH %s expected %h actual %h", name, exp, act);
		$display("Some tests failed");
		$fatal(1, "key compare");
	end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("MISMATCH %s expected %h actual %h", name, exp, act);
		$display("Some tests failed");
		$fatal(1, "byte compare");
	end
endtask

`endif

// ==== tb_vp_glue.sv ====
/*
 * Testbench for the console glue top level
 * Clock, reset, stim file reader, record sequencing and timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vp_glue import vp_pkg::*; ();

	logic                   clk_sys;
	logic                   reset;
	video_std_t             pal_i;
	logic                   download_i, wr_i, bs0_i, bs1_i, psen_n_i;
	logic [CART_ROM_AW-1:0] dl_addr_i;
	logic             [7:0] dl_data_i, cart_d_o;
	cart_addr_t             cart_a_i;
	pixel_code_t            pixel_i;
	chan_t                  r_o, g_o, b_o;
	ps2_key_t               ps2_key_i;
	numpad_t                numpad_i;
	logic                   key_valid_o, key_released_o;
	ascii_t                 key_ascii_o;
	logic                   cpu_en_o, vdc_en_o, core_reset_o;

	string kinds[$];   // One entry per record
	int    fields[$];  // Six fields per record
	int    limit;
	int    cycle_cnt;

	`include "tb_vp_checks.svh"

	vp_glue_top #(.CART_ROM_AW(CART_ROM_AW)) i_dut (.*);

	always #10 clk_sys = ~clk_sys;

	// Watchdog
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit > 0 && cycle_cnt >= limit) begin
			$display("Run exceeded its cycle limit of %0d", limit);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic step_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "testbench error");
	endtask

	////////////////////////////////////////////////////////////////////////
	// Record handlers

	task automatic check_enables(input int cpu_div, input int vdc_div, input int cycles);
		for (int n = 1; n <= cycles; n++) begin
			step_cycle();
			check_bit($sformatf("cpu_en cycle %0d", n), n % cpu_div == 0, cpu_en_o);
			check_bit($sformatf("vdc_en cycle %0d", n), n % vdc_div == 0, vdc_en_o);
		end
	endtask

	task automatic change_standard(input int std, input int cpu_div, input int vdc_div,
		input int cycles);
		if (video_std_t'(std) == pal_i)
			stop_on_error("CLK record does not change the video standard");
		pal_i = video_std_t'(std);
		#1;
		check_bit("core_reset on standard change", 1'b1, core_reset_o);
		step_cycle();
		check_bit("core_reset after one cycle", 1'b0, core_reset_o);
		check_enables(cpu_div, vdc_div, cycles);
	endtask

	task automatic check_palette(input int std, input int code, input int r, input int g,
		input int b);
		string name;
		name = $sformatf("palette std %0d code %0h", std, code);
		pal_i   = video_std_t'(std);
		pixel_i = pixel_code_t'(code);
		step_cycle();
		check_chan({name, " r"}, chan_t'(r), r_o);
		check_chan({name, " g"}, chan_t'(g), g_o);
		check_chan({name, " b"}, chan_t'(b), b_o);
	endtask

	task automatic send_key_event(input string name, input logic tog, input int scan,
		input int pressed, input int ext, input logic new_np, input int vec,
		input int exp_ascii, input int exp_rel);
		if (tog)
			ps2_key_i = {~ps2_key_i[10], 1'(pressed), 1'(ext), 8'(scan)};
		if (new_np)
			numpad_i = numpad_t'(vec);
		step_cycle();
		check_bit({name, " valid early"}, 1'b0, key_valid_o);
		step_cycle();
		check_bit({name, " valid"}, 1'b1, key_valid_o);
		check_ascii({name, " ascii"}, ascii_t'(exp_ascii), key_ascii_o);
		check_bit({name, " released"}, 1'(exp_rel), key_released_o);
		step_cycle();
		check_bit({name, " valid late"}, 1'b0, key_valid_o);
	endtask

	// Byte pattern over all 13 address bits
	function automatic logic [7:0] fill_byte(input logic [12:0] a);
		return a[7:0] ^ {a[12:8], 3'b000};
	endfunction

	task automatic load_cartridge(input int n);
		download_i = 1'b1;
		wr_i       = 1'b0;
		step_cycle();
		check_bit("core_reset during download", 1'b1, core_reset_o);
		for (int a = 0; a < n; a++) begin
			wr_i      = 1'b1;
			dl_addr_i = CART_ROM_AW'(a);
			dl_data_i = fill_byte(13'(a));
			step_cycle();
		end
		wr_i       = 1'b0;
		download_i = 1'b0;
		step_cycle();
	endtask

	task automatic read_cartridge(input int n, input int a, input int bs0, input int bs1,
		input int psen_n, input int exp_d);
		cart_a_i = cart_addr_t'(a);
		bs0_i    = 1'(bs0);
		bs1_i    = 1'(bs1);
		psen_n_i = 1'(psen_n);
		step_cycle();
		check_byte($sformatf("cart size %0h addr %0h", n, a), 8'(exp_d), cart_d_o);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Stim file and sequencing

	task automatic read_stim(output int total);
		int    fd, code, prev_size;
		int    v[6];
		string kind, line;
		total     = 0;
		prev_size = 0;
		fd = $fopen("vp_glue_stim.txt", "r");
		if (fd == 0)
			stop_on_error("Cannot open vp_glue_stim.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1)
				break;
			if (kind.substr(0, 0) == "#") begin
				code = $fgets(line, fd);
				continue;
			end
			code = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
			if (code != 6)
				stop_on_error({"Malformed stim record of kind ", kind});
			kinds.push_back(kind);
			for (int k = 0; k < 6; k++)
				fields.push_back(v[k]);
			case (kind)
				"CLK":  total += v[3] + 2;
				"PAL":  total += 1;
				"KEY", "JOY": total += 3;
				"CART": begin
					total += 1;
					if (v[0] != prev_size)
						total += v[0] + 2;
					prev_size = v[0];
				end
				default: stop_on_error({"Unknown stim record kind ", kind});
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		int total, size, b;
		clk_sys    = 1'b0;
		reset      = 1'b1;
		pal_i      = STD_NTSC;
		download_i = 1'b0;
		wr_i       = 1'b0;
		dl_addr_i  = '0;
		dl_data_i  = 8'h00;
		cart_a_i   = '0;
		bs0_i      = 1'b0;
		bs1_i      = 1'b0;
		psen_n_i   = 1'b1;
		pixel_i    = '0;
		ps2_key_i  = '0;
		numpad_i   = '0;
		cycle_cnt  = 0;
		limit      = 0;
		size       = 0;

		read_stim(total);
		limit = total + 16 + 2 * CPU_DIV_PAL + 100;

		repeat (16) step_cycle();
		check_bit("core_reset during reset", 1'b1, core_reset_o);
		reset = 1'b0;
		check_enables(CPU_DIV_NTSC, VDC_DIV_NTSC, 2 * CPU_DIV_PAL);

		foreach (kinds[i]) begin
			b = i * 6;
			case (kinds[i])
				"CLK": change_standard(fields[b], fields[b+1], fields[b+2], fields[b+3]);
				"PAL": check_palette(fields[b], fields[b+1], fields[b+2], fields[b+3],
					fields[b+4]);
				"KEY": send_key_event($sformatf("key %0h", fields[b]), 1'b1, fields[b],
					fields[b+1], fields[b+2], 1'b0, 0, fields[b+3], fields[b+4]);
				"JOY": send_key_event($sformatf("joy %0h", fields[b]), 1'(fields[b+1]),
					fields[b+2], 1, 0, 1'b1, fields[b], fields[b+3], fields[b+4]);
				default: begin // CART
					if (fields[b] != size)
						load_cartridge(fields[b]);
					size = fields[b];
					read_cartridge(fields[b], fields[b+1], fields[b+2], fields[b+3],
						fields[b+4], fields[b+5]);
				end
			endcase
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
vp_pkg.sv
vp_timing_ctrl.sv
vp_palette.sv
vp_key_event.sv
vp_key_translate.sv
vp_cart_map.sv
vp_cart_rom.sv
vp_glue_top.sv
tb_vp_glue.sv

// ==== Makefile ====
# Verilator flow for the console glue testbench

VERILATOR ?= verilator
TOP       ?= tb_vp_glue
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulator exits non-zero when the testbench stops on $$fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== vp_glue_stim.txt ====
# kind and six hex fields: CLK std cpu_div vdc_div cycles 0 0, PAL std code r g b 0
# KEY scan pressed ext ascii rel 0, JOY vec tog scan ascii rel 0, CART size addr bs0 bs1 psen_n data
CLK 1 c a 3c 0 0
CLK 0 8 6 3c 0 0
PAL 0 0 00 00 00 0
PAL 0 1 19 19 19 0
PAL 0 2 06 0d 2f 0
PAL 0 3 17 20 3d 0
PAL 0 4 00 1b 01 0
PAL 0 5 15 31 1a 0
PAL 0 6 0a 2a 2f 0
PAL 0 7 1d 39 3a 0
PAL 0 8 1e 00 00 0
PAL 0 9 31 14 14 0
PAL 0 a 25 0c 27 0
PAL 0 b 37 21 3a 0
PAL 0 c 1d 19 02 0
PAL 0 d 31 2e 1a 0
PAL 0 e 33 33 33 0
PAL 0 f 3f 3f 3f 0
PAL 1 0 00 00 00 0
PAL 1 1 12 12 12 0
PAL 1 2 00 00 2d 0
PAL 1 3 12 12 3f 0
PAL 1 4 00 2d 00 0
PAL 1 5 12 3f 12 0
PAL 1 6 00 2d 32 0
PAL 1 7 12 3f 3f 0
PAL 1 8 2d 00 00 0
PAL 1 9 3f 12 12 0
PAL 1 a 2d 00 2d 0
PAL 1 b 3f 12 3f 0
PAL 1 c 2d 2d 00 0
PAL 1 d 3f 3f 12 0
PAL 1 e 2d 2d 2d 0
PAL 1 f 3f 3f 3f 0
KEY 16 1 0 31 0 0
KEY 1c 0 0 61 1 0
KEY 5a 1 1 0a 0 0
KEY 1f 1 0 11 0 0
KEY 79 1 0 2b 0 0
KEY 0e 1 0 00 0 0
KEY 29 0 0 20 1 0
JOY 014 0 00 33 0 0
JOY 000 0 00 33 1 0
JOY 200 0 00 30 0 0
JOY 000 0 00 30 1 0
JOY 001 1 1c 61 0 0
JOY 000 0 00 30 1 0
CART 800 123 1 1 0 2b
CART 800 a55 1 1 0 65
CART 800 123 1 1 1 ff
CART 1000 3a3 1 1 0 fb
CART 1000 812 0 1 0 32
CART 2000 9f0 1 1 0 18
CART 2000 005 0 1 0 85
CART 2000 005 0 1 1 ff
